/* all.f */
logic/hps_pkg.sv
logic/uio_sequencer.sv
logic/core_regs.sv
logic/ps2_key_decoder.sv
logic/file_loader.sv
logic/hps_bridge.sv
tests/hps_bridge_sva.sv
tests/hps_bridge_tb.sv

/* Makefile */
# Verilator build and run of the bridge testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module hps_bridge_tb \
		-f all.f -Mdir obj_dir -o hps_bridge_sim
	./obj_dir/hps_bridge_sim | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) && echo "test ok" || (echo "test failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* tests/hps_bridge_tb.sv */
// bridge directed testbench
`timescale 1ns/1ns

module hps_bridge_tb import hps_pkg::*; ();

	localparam int TEST_COUNT = 5;
	localparam int MAX_WORDS  = 6;
	localparam int DL_BYTES   = 5;

	logic                clk_sys;
	logic                rst_n;
	host_bus_t           host;
	logic [63:0]         status_in;
	logic                status_set;
	logic [15:0]         io_dout;
	logic [15:0]         fp_dout;
	logic [1:0]          buttons;
	logic                forced_scandoubler;
	logic                direct_video;
	joy_array_t          joystick;
	logic [63:0]         status;
	ps2_key_t            ps2_key;
	logic                ioctl_download;
	logic                ioctl_wr;
	logic [15:0]         ioctl_index;
	logic [31:0]         ioctl_file_ext;
	logic [IOCTL_AW-1:0] ioctl_addr;
	logic [7:0]          ioctl_dout;

	integer      seed;
	int          wr_count;
	logic [15:0] tx_words [$];
	logic [15:0] rx_words [$];
	logic [7:0]  dl_bytes [DL_BYTES];

	hps_bridge uut (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.host               (host),
		.io_dout            (io_dout),
		.fp_dout            (fp_dout),
		.status_in          (status_in),
		.status_set         (status_set),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick           (joystick),
		.status             (status),
		.ps2_key            (ps2_key),
		.ioctl_download     (ioctl_download),
		.ioctl_wr           (ioctl_wr),
		.ioctl_index        (ioctl_index),
		.ioctl_file_ext     (ioctl_file_ext),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	//////////////////////////////
	// failure reporting and compares
	//////////////////////////////

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (exp !== act) begin
			stop_with_error($sformatf("Fail %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_joy(input string name, input joy_array_t exp, input joy_array_t act);
		if (exp !== act) begin
			stop_with_error($sformatf("Fail %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_key(input string name, input ps2_key_t exp, input ps2_key_t act);
		if (exp !== act) begin
			stop_with_error($sformatf("Fail %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_status(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			stop_with_error($sformatf("Fail %s expected %h actual %h", name, exp, act));
		end
	endtask

	function automatic ps2_key_t make_key(input logic tgl, input logic pressed, input logic ext,
		input logic [7:0] code);
		ps2_key_t k;
		k.toggle   = tgl;
		k.pressed  = pressed;
		k.extended = ext;
		k.code     = code;
		return k;
	endfunction

	//////////////////////////////
	// bus drivers
	//////////////////////////////

	// one framed command from tx_words, replies collected in rx_words
	task automatic send_words(input logic file_ch);
		int i;
		rx_words.delete();
		host.io_enable = ~file_ch;
		host.fp_enable = file_ch;
		@(posedge clk_sys);
		#10;
		for (i = 0; i < tx_words.size(); i++) begin
			host.io_strobe = 1'b1;
			host.io_din    = tx_words[i];
			@(posedge clk_sys);
			#10;
			host.io_strobe = 1'b0;
			rx_words.push_back(io_dout);
			repeat (2) @(posedge clk_sys);
			#10;
		end
		host.io_enable = 1'b0;
		host.fp_enable = 1'b0;
		repeat (3) @(posedge clk_sys);
		#10;
		tx_words.delete();
	endtask

	task automatic send_uio();
		send_words(1'b0);
	endtask

	task automatic send_fio();
		send_words(1'b1);
	endtask

	task automatic pulse_status_set(input logic [63:0] value);
		status_in  = value;
		status_set = 1'b1;
		repeat (2) @(posedge clk_sys);
		#10;
		status_set = 1'b0;
		repeat (3) @(posedge clk_sys);
		#10;
	endtask

	// each write pulse must land at 0x100 plus its number
	always @(negedge clk_sys) begin
		if (rst_n && ioctl_wr) begin
			if (wr_count >= DL_BYTES) begin
				stop_with_error("more write pulses than data bytes sent");
			end
			check_status("download address", 64'h100 + 64'(wr_count), 64'(ioctl_addr));
			check_word("download data", {8'h00, dl_bytes[wr_count]}, {8'h00, ioctl_dout});
			wr_count++;
		end
	end

	//////////////////////////////
	// directed tests
	//////////////////////////////

	task automatic reset_values();
		check_word("reset io_dout", 16'h0000, io_dout);
		check_word("reset fp_dout", 16'h0000, fp_dout);
		check_word("reset config", 16'h0000, {12'h0, direct_video, forced_scandoubler, buttons});
		check_joy("reset joystick", '0, joystick);
		check_status("reset status", 64'h0, status);
		check_key("reset ps2_key", '0, ps2_key);
		check_word("reset ioctl flags", 16'h0000, {14'h0, ioctl_download, ioctl_wr});
		check_word("reset ioctl_index", 16'h0000, ioctl_index);
		check_status("reset ioctl_file_ext", 64'h0, {32'h0, ioctl_file_ext});
		check_status("reset ioctl_addr", 64'h0, 64'(ioctl_addr));
		check_word("reset ioctl_dout", 16'h0000, {8'h00, ioctl_dout});
	endtask

	task automatic register_writes();
		uio_cmd_e    joy_ops [JOY_COUNT];
		joy_array_t  exp_joy;
		logic [63:0] exp_status;
		logic [31:0] val;
		int          j;
		joy_ops = '{UIO_JOY0, UIO_JOY1, UIO_JOY2, UIO_JOY3};
		tx_words.push_back(UIO_CFG);
		tx_words.push_back(16'h0413);
		send_uio();
		check_word("config", {12'h0, 1'b1, 1'b1, 2'b11},
			{12'h0, direct_video, forced_scandoubler, buttons});
		for (j = 0; j < JOY_COUNT; j++) begin
			val        = $random(seed);
			exp_joy[j] = val;
			tx_words.push_back(joy_ops[j]);
			tx_words.push_back(val[15:0]);
			tx_words.push_back(val[31:16]);
			send_uio();
		end
		check_joy("joystick", exp_joy, joystick);
		exp_status = {$random(seed), $random(seed)};
		tx_words.push_back(UIO_STATUS);
		for (j = 0; j < 4; j++) begin
			tx_words.push_back(exp_status[j*16 +: 16]);
		end
		send_uio();
		check_status("status write", exp_status, status);
	endtask

	task automatic status_readback();
		logic [63:0] value;
		int          q;
		pulse_status_set({$random(seed), $random(seed)});
		value = {$random(seed), $random(seed)};
		pulse_status_set(value);
		tx_words.push_back(UIO_STATUS_REQ);
		repeat (4) tx_words.push_back(16'h0000);
		send_uio();
		check_word("status request header", {8'h00, STATUS_TAG, 4'd2}, rx_words[0]);
		for (q = 0; q < 4; q++) begin
			check_word("status request quarter", value[q*16 +: 16], rx_words[q+1]);
		end
	endtask

	task automatic key_events();
		logic tgl;
		tgl = 1'b0;
		tx_words.push_back(UIO_PS2_KEY);
		tx_words.push_back(16'h001C);
		send_uio();
		tgl = ~tgl;
		check_key("key plain", make_key(tgl, 1'b1, 1'b0, 8'h1C), ps2_key);
		tx_words.push_back(UIO_PS2_KEY);
		tx_words.push_back(16'h00F0);
		tx_words.push_back(16'h001C);
		send_uio();
		tgl = ~tgl;
		check_key("key released", make_key(tgl, 1'b0, 1'b0, 8'h1C), ps2_key);
		tx_words.push_back(UIO_PS2_KEY);
		tx_words.push_back(16'h00E0);
		tx_words.push_back(16'h0075);
		send_uio();
		tgl = ~tgl;
		check_key("key extended", make_key(tgl, 1'b1, 1'b1, 8'h75), ps2_key);
		tx_words.push_back(UIO_PS2_KEY);
		tx_words.push_back(16'h00E0);
		tx_words.push_back(16'h0012);
		tx_words.push_back(16'h00E0);
		tx_words.push_back(16'h007C);
		send_uio();
		tgl = ~tgl;
		check_key("key print-screen", make_key(tgl, 1'b1, 1'b1, 8'h7C), ps2_key);
		// all-ones high byte leaves the last event in place
		tx_words.push_back(UIO_PS2_KEY);
		tx_words.push_back(16'hFF00);
		send_uio();
		check_key("key skipped", make_key(tgl, 1'b1, 1'b1, 8'h7C), ps2_key);
	endtask

	task automatic file_download();
		int n;
		tx_words.push_back(FIO_FILE_INDEX);
		tx_words.push_back(16'h0003);
		send_fio();
		check_word("file index", 16'h0003, ioctl_index);
		tx_words.push_back(FIO_FILE_INFO);
		tx_words.push_back(16'h4249);
		tx_words.push_back(16'h4E00);
		send_fio();
		check_status("file extension", 64'h42494E00, {32'h0, ioctl_file_ext});
		tx_words.push_back(FIO_FILE_TX);
		tx_words.push_back(16'h0001);
		tx_words.push_back(16'h0100);
		tx_words.push_back(16'h0000);
		send_fio();
		check_word("download start", 16'h0001, {15'h0, ioctl_download});
		wr_count = 0;
		tx_words.push_back(FIO_FILE_TX_DAT);
		for (n = 0; n < DL_BYTES; n++) begin
			dl_bytes[n] = 8'($random(seed));
			tx_words.push_back({8'h00, dl_bytes[n]});
		end
		send_fio();
		check_word("write pulse count", 16'(DL_BYTES), 16'(wr_count));
		tx_words.push_back(FIO_FILE_TX);
		tx_words.push_back(16'h0000);
		send_fio();
		check_word("download end", 16'h0000, {15'h0, ioctl_download});
	endtask

	// the whole run must fit in this time
	initial begin
		#(TEST_COUNT * MAX_WORDS * 2000);
		stop_with_error("watchdog timeout, the tests did not finish in time");
	end

	initial begin
		seed       = 32'hccc33de2;
		wr_count   = 0;
		host       = '0;
		status_in  = 64'h0;
		status_set = 1'b0;
		rst_n      = 1'b0;
		repeat (4) @(posedge clk_sys);
		#10;
		rst_n = 1'b1;
		reset_values();
		register_writes();
		status_readback();
		key_events();
		file_download();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* tests/hps_bridge_sva.sv */
// bridge timing assertions
`timescale 1ns/1ns

module hps_bridge_sva import hps_pkg::*; (
	input logic        clk_sys,
	input logic        rst_n,
	input logic        io_enable,
	input logic [15:0] io_dout,
	input logic        end_cmd,
	input ps2_key_t    ps2_key,
	input logic        ioctl_download,
	input logic        ioctl_wr
);

	// write strobe is a lone pulse
	wr_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wr |=> !ioctl_wr)
		else $error("ioctl_wr held for more than one cycle");

	wr_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wr |-> ioctl_download)
		else $error("ioctl_wr pulsed outside a download");

	// reply bus clears once the frame closes
	dout_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!io_enable |=> (io_dout == 16'h0000))
		else $error("io_dout not zero after io_enable low");

	key_after_end: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$changed(ps2_key) |-> $past(end_cmd))
		else $error("ps2_key changed without an end pulse");

endmodule

bind file_loader hps_bridge_sva u_load_sva (
	.clk_sys        (clk_sys),
	.rst_n          (rst_n),
	.io_enable      (1'b1),
	.io_dout        (16'h0000),
	.end_cmd        (1'b0),
	.ps2_key        (11'h000),
	.ioctl_download (ioctl_download),
	.ioctl_wr       (ioctl_wr)
);

bind uio_sequencer hps_bridge_sva u_seq_sva (
	.clk_sys        (clk_sys),
	.rst_n          (rst_n),
	.io_enable      (host.io_enable),
	.io_dout        (io_dout),
	.end_cmd        (1'b0),
	.ps2_key        (11'h000),
	.ioctl_download (1'b0),
	.ioctl_wr       (1'b0)
);

bind ps2_key_decoder hps_bridge_sva u_key_sva (
	.clk_sys        (clk_sys),
	.rst_n          (rst_n),
	.io_enable      (1'b1),
	.io_dout        (16'h0000),
	.end_cmd        (word.end_cmd),
	.ps2_key        (ps2_key),
	.ioctl_download (1'b0),
	.ioctl_wr       (1'b0)
);

/* logic/hps_bridge.sv */
// host to core bridge top
`timescale 1ns/1ns

module hps_bridge import hps_pkg::*; (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  host_bus_t           host,
	output logic [15:0]         io_dout,
	output logic [15:0]         fp_dout,
	input  logic [63:0]         status_in,
	input  logic                status_set,
	output logic [1:0]          buttons,
	output logic                forced_scandoubler,
	output logic                direct_video,
	output joy_array_t          joystick,
	output logic [63:0]         status,
	output ps2_key_t            ps2_key,
	output logic                ioctl_download,
	output logic                ioctl_wr,
	output logic [15:0]         ioctl_index,
	output logic [31:0]         ioctl_file_ext,
	output logic [IOCTL_AW-1:0] ioctl_addr,
	output logic [7:0]          ioctl_dout
);

	uio_word_t   uio_word;
	status_req_t status_req;

	// no upload path, file channel never answers
	assign fp_dout = 16'h0000;

	//////////////////////////////
	// user-I/O channel
	//////////////////////////////

	uio_sequencer u_seq (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.host    (host),
		.req     (status_req),
		.word    (uio_word),
		.io_dout (io_dout)
	);

	core_regs u_regs (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.word               (uio_word),
		.status_in          (status_in),
		.status_set         (status_set),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick           (joystick),
		.status             (status),
		.req                (status_req)
	);

	ps2_key_decoder u_key (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.word    (uio_word),
		.ps2_key (ps2_key)
	);

	//////////////////////////////
	// file channel
	//////////////////////////////

	file_loader u_load (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.host           (host),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

/* logic/file_loader.sv */
// file download channel
`timescale 1ns/1ns

module file_loader import hps_pkg::*; (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  host_bus_t           host,
	output logic                ioctl_download,
	output logic                ioctl_wr,
	output logic [15:0]         ioctl_index,
	output logic [31:0]         ioctl_file_ext,
	output logic [IOCTL_AW-1:0] ioctl_addr,
	output logic [7:0]          ioctl_dout
);

	fio_cmd_e            cmd;
	logic                has_cmd;
	logic [1:0]          cnt;
	logic [IOCTL_AW-1:0] addr;
	logic                wr;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cmd            <= FIO_FILE_TX;
			has_cmd        <= 1'b0;
			cnt            <= 2'd0;
			addr           <= '0;
			wr             <= 1'b0;
			ioctl_download <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_index    <= 16'h0000;
			ioctl_file_ext <= 32'h0;
			ioctl_addr     <= '0;
			ioctl_dout     <= 8'h00;
		end else begin
			// write strobe trails the data by one cycle
			ioctl_wr <= wr;
			wr       <= 1'b0;

			if (!host.fp_enable) begin
				has_cmd <= 1'b0;
			end else if (host.io_strobe) begin
				if (!has_cmd) begin
					cmd     <= fio_cmd_e'(host.io_din);
					has_cmd <= 1'b1;
					cnt     <= 2'd0;
				end else begin
					if (cnt != 2'd3) begin
						cnt <= cnt + 2'd1;
					end

					case (cmd)
						FIO_FILE_INDEX: ioctl_index <= host.io_din;

						// extension arrives high half first
						FIO_FILE_INFO: begin
							if (cnt == 2'd0) begin
								ioctl_file_ext[31:16] <= host.io_din;
							end else if (cnt == 2'd1) begin
								ioctl_file_ext[15:0] <= host.io_din;
							end
						end

						FIO_FILE_TX: begin
							case (cnt)
								2'd0: begin
									if (host.io_din[7:0] != 8'h00) begin
										addr           <= '0;
										ioctl_addr     <= '0;
										ioctl_download <= 1'b1;
									end else begin
										// leave the end address visible
										if (ioctl_download) begin
											ioctl_addr <= addr;
										end
										ioctl_download <= 1'b0;
									end
								end
								2'd1: begin
									ioctl_addr[15:0] <= host.io_din;
									addr[15:0]       <= host.io_din;
								end
								2'd2: begin
									ioctl_addr[IOCTL_AW-1:16] <= host.io_din[IOCTL_AW-17:0];
									addr[IOCTL_AW-1:16]       <= host.io_din[IOCTL_AW-17:0];
								end
								default: ;
							endcase
						end

						FIO_FILE_TX_DAT: begin
							if (ioctl_download) begin
								ioctl_addr <= addr;
								ioctl_dout <= host.io_din[7:0];
								wr         <= 1'b1;
								addr       <= addr + 1'b1;
							end
						end

						default: ;
					endcase
				end
			end
		end
	end

endmodule

/* logic/ps2_key_decoder.sv */
// keyboard event decoder
`timescale 1ns/1ns

module ps2_key_decoder import hps_pkg::*; (
	input  logic      clk_sys,
	input  logic      rst_n,
	input  uio_word_t word,
	output ps2_key_t  ps2_key
);

	logic [31:0] raw;
	logic        skip;
	logic        is_key;
	logic        hi_ones;
	ps2_key_t    key_next;

	assign is_key  = (word.cmd == UIO_PS2_KEY);
	assign hi_ones = &word.data[15:8];

	// event from the collected bytes
	always_comb begin
		key_next.toggle   = ~ps2_key.toggle;
		key_next.pressed  = (raw[15:8] != 8'hF0);
		key_next.extended = key_next.pressed ? (raw[15:8] == 8'hE0) : (raw[23:16] == 8'hE0);
		key_next.code     = raw[7:0];

		// print-screen and pause sequences
		case (raw)
			32'hE012E07C: {key_next.pressed, key_next.extended, key_next.code} = {2'b11, 8'h7C};
			32'h7CE0F012: {key_next.pressed, key_next.extended, key_next.code} = {2'b01, 8'h7C};
			32'hF014F077: {key_next.pressed, key_next.extended, key_next.code} = {2'b11, 8'h77};
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			raw     <= 32'h0;
			skip    <= 1'b0;
			ps2_key <= '0;
		end else if (word.valid && is_key) begin
			if (word.idx == 6'd1) begin
				skip <= hi_ones;
				raw  <= hi_ones ? 32'h0 : {24'h0, word.data[7:0]};
			end else if (hi_ones) begin
				skip <= 1'b1;
			end else if (!skip) begin
				raw <= {raw[23:0], word.data[7:0]};
			end
		end else if (word.end_cmd) begin
			skip <= 1'b0;
			if (is_key && !skip) begin
				ps2_key <= key_next;
			end
		end
	end

endmodule

/* logic/core_regs.sv */
// core side control registers
`timescale 1ns/1ns

module core_regs import hps_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  uio_word_t   word,
	input  logic [63:0] status_in,
	input  logic        status_set,
	output logic [1:0]  buttons,
	output logic        forced_scandoubler,
	output logic        direct_video,
	output joy_array_t  joystick,
	output logic [63:0] status,
	output status_req_t req
);

	logic [15:0] cfg;
	logic        joy_hit;
	logic [1:0]  joy_idx;
	logic        set_sync;
	logic        set_q;

	// config word fields
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	// joystick opcode to slot
	always_comb begin
		joy_hit = word.valid;
		joy_idx = 2'd0;
		case (word.cmd)
			UIO_JOY0: joy_idx = 2'd0;
			UIO_JOY1: joy_idx = 2'd1;
			UIO_JOY2: joy_idx = 2'd2;
			UIO_JOY3: joy_idx = 2'd3;
			default:  joy_hit = 1'b0;
		endcase
	end

	//////////////////////////////
	// host written registers
	//////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cfg      <= 16'h0000;
			joystick <= '0;
			status   <= 64'h0;
		end else if (word.valid) begin
			if (word.cmd == UIO_CFG && word.idx == 6'd1) begin
				cfg <= word.data;
			end

			if (joy_hit) begin
				if (word.idx == 6'd1) begin
					joystick[joy_idx][15:0] <= word.data;
				end else if (word.idx == 6'd2) begin
					joystick[joy_idx][31:16] <= word.data;
				end
			end

			// 64-bit status, low quarter first
			if (word.cmd == UIO_STATUS) begin
				case (word.idx)
					6'd1: status[15:0]  <= word.data;
					6'd2: status[31:16] <= word.data;
					6'd3: status[47:32] <= word.data;
					6'd4: status[63:48] <= word.data;
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////
	// core status-set request
	//////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			set_sync <= 1'b0;
			set_q    <= 1'b0;
			req      <= '0;
		end else begin
			set_sync <= status_set;
			set_q    <= set_sync;
			if (set_sync && !set_q) begin
				req.count  <= req.count + 4'd1;
				req.status <= status_in;
			end
		end
	end

endmodule

/* logic/uio_sequencer.sv */
// user-I/O command sequencer
`timescale 1ns/1ns

module uio_sequencer import hps_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  host_bus_t   host,
	input  status_req_t req,
	output uio_word_t   word,
	output logic [15:0] io_dout
);

	uio_cmd_e    cmd;
	logic [5:0]  cnt;
	logic [15:0] reply;

	//////////////////////////////
	// host reply for the current strobe
	//////////////////////////////

	always_comb begin
		reply = 16'h0000;
		if (cnt == 6'd0) begin
			// opcode word, only status-set answers
			if (host.io_din == UIO_STATUS_REQ) begin
				reply = {8'h00, STATUS_TAG, req.count};
			end
		end else if (cmd == UIO_STATUS_REQ) begin
			case (cnt)
				6'd1: reply = req.status[15:0];
				6'd2: reply = req.status[31:16];
				6'd3: reply = req.status[47:32];
				6'd4: reply = req.status[63:48];
				default: reply = 16'h0000;
			endcase
		end
	end

	//////////////////////////////
	// framing and word events
	//////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cmd     <= UIO_NONE;
			cnt     <= 6'd0;
			io_dout <= 16'h0000;
			word    <= '0;
		end else begin
			// pulses last one cycle
			word.valid   <= 1'b0;
			word.end_cmd <= 1'b0;

			if (!host.io_enable) begin
				// a nonzero count means an opcode was taken
				if (cnt != 6'd0) begin
					word.end_cmd <= 1'b1;
					word.cmd     <= cmd;
				end
				cmd     <= UIO_NONE;
				cnt     <= 6'd0;
				io_dout <= 16'h0000;
			end else if (host.io_strobe) begin
				io_dout <= reply;

				// index sticks at the top
				if (cnt != 6'h3F) begin
					cnt <= cnt + 6'd1;
				end

				if (cnt == 6'd0) begin
					cmd <= uio_cmd_e'(host.io_din);
				end else begin
					word.valid <= 1'b1;
					word.cmd   <= cmd;
					word.idx   <= cnt;
					word.data  <= host.io_din;
				end
			end
		end
	end

endmodule

/* logic/hps_pkg.sv */
// host bridge shared types

package hps_pkg;

	//////////////////////////////
	// fixed protocol widths
	//////////////////////////////

	localparam int JOY_COUNT = 4;
	localparam int IOCTL_AW = 27;

	// prefix nibble of the status-set reply
	localparam logic [3:0] STATUS_TAG = 4'hA;

	//////////////////////////////
	// opcodes
	//////////////////////////////

	typedef enum logic [15:0] {
		UIO_NONE       = 16'h0000,
		UIO_CFG        = 16'h0001,
		UIO_JOY0       = 16'h0002,
		UIO_JOY1       = 16'h0003,
		UIO_PS2_KEY    = 16'h0005,
		UIO_JOY2       = 16'h0010,
		UIO_JOY3       = 16'h0011,
		UIO_STATUS     = 16'h001E,
		UIO_STATUS_REQ = 16'h0029
	} uio_cmd_e;

	typedef enum logic [15:0] {
		FIO_FILE_TX     = 16'h0053,
		FIO_FILE_TX_DAT = 16'h0054,
		FIO_FILE_INDEX  = 16'h0055,
		FIO_FILE_INFO   = 16'h0056
	} fio_cmd_e;

	//////////////////////////////
	// bus and event structs
	//////////////////////////////

	// host side of the word-serial bus
	typedef struct packed {
		logic        io_enable;
		logic        fp_enable;
		logic        io_strobe;
		logic [15:0] io_din;
	} host_bus_t;

	// one decoded user-I/O event
	typedef struct packed {
		logic        valid;
		logic        end_cmd;
		uio_cmd_e    cmd;
		logic [5:0]  idx;
		logic [15:0] data;
	} uio_word_t;

	typedef struct packed {
		logic [3:0]  count;
		logic [63:0] status;
	} status_req_t;

	typedef logic [JOY_COUNT-1:0][31:0] joy_array_t;

	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

endpackage
